//--- design/conv_params.svh
// multiplier latency at least 1; the accumulator must hold the longest input-channel run
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// pixel and weight words are signed
`define CONV_WORD_WIDTH 8

// one output sum per member and unit
`define CONV_ACC_WIDTH 24

// pixels carried by one input beat
`define CONV_UNITS 2

// output channels, one weight each per beat
`define CONV_MEMBERS 4

// enabled cycles from operands to product
`define CONV_LATENCY_MUL 3

`endif

//--- design/conv_pkg.sv
// word, product, sum and opcode types of the 1x1 engine. Widths follow the params header
`include "conv_params.svh"

package conv_pkg;

  // one signed pixel or weight
  typedef logic signed [`CONV_WORD_WIDTH-1:0] word_t;

  // full precision product of two words
  typedef logic signed [2*`CONV_WORD_WIDTH-1:0] prod_t;

  // running sum over the input channels
  typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

  // accumulator opcode
  // load starts a fresh sum with the addend, add extends the current one
  typedef enum logic {
    ACC_LOAD = 1'b0,
    ACC_ADD  = 1'b1
  } acc_op_e;

endpackage

//--- design/mul_pipe.sv
// signed multiplier over CONV_LATENCY_MUL enabled stages; en is the only stall
`timescale 1ns/100ps
`include "conv_params.svh"

module mul_pipe (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            en,
  input  conv_pkg::word_t pixel,
  input  conv_pkg::word_t weight,
  output conv_pkg::prod_t product
);

  localparam int LATENCY = `CONV_LATENCY_MUL;

  conv_pkg::prod_t pixel_ext;
  conv_pkg::prod_t weight_ext;
  conv_pkg::prod_t raw;
  conv_pkg::prod_t stage [LATENCY]; // stage 0 takes the raw product

  assign pixel_ext  = conv_pkg::prod_t'(pixel); // sign extended
  assign weight_ext = conv_pkg::prod_t'(weight);
  assign raw        = pixel_ext * weight_ext; // exact, 8x8 fits in 16

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < LATENCY; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= raw;
      for (int i = 1; i < LATENCY; i++) begin
        stage[i] <= stage[i-1]; // plain shift, no further arithmetic
      end
    end
  end

  assign product = stage[LATENCY-1];

endmodule

//--- design/acc_unit.sv
// single-cycle accumulator; sums wrap silently if a run exceeds CONV_ACC_WIDTH
`timescale 1ns/100ps
`include "conv_params.svh"

module acc_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               en,
  input  conv_pkg::acc_op_e  op,
  input  conv_pkg::prod_t    addend,
  output conv_pkg::acc_t     sum
);

  conv_pkg::acc_t addend_ext;

  assign addend_ext = conv_pkg::acc_t'(addend); // sign extension to sum width

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum <= '0;
    end else if (en) begin
      unique case (op)
        conv_pkg::ACC_LOAD: sum <= addend_ext;       // first beat of a group
        conv_pkg::ACC_ADD:  sum <= sum + addend_ext; // later beats, idle slots add 0
        default:            sum <= sum;
      endcase
    end
  end

  // an X opcode on an enabled edge would corrupt every later sum of the group
  a_op_known : assert property (
    @(posedge clk) disable iff (!arst_n)
    en |-> !$isunknown(op)
  ) else $error("acc_unit: opcode unknown while enabled");

endmodule

//--- design/conv_ctrl.sv
// accumulator latency is fixed at 1 and beats are never refused; a slow sink lowers clken
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              clken,
  input  logic              s_valid,
  input  logic              s_last,
  input  logic              s_cin_last,
  output logic              mul_valid,
  output conv_pkg::acc_op_e acc_op,
  output logic              acc_en,
  output logic              m_valid,
  output logic              m_last
);

  localparam int LATENCY = `CONV_LATENCY_MUL;

  logic [LATENCY-1:0] valid_sr;    // tracks beats through the multipliers
  logic [LATENCY-1:0] last_sr;
  logic [LATENCY-1:0] cin_last_sr;
  logic               mul_last;
  logic               mul_cin_last;
  logic               load_flag;   // next valid beat opens a new group
  logic               m_valid_q;
  logic               m_last_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_sr    <= '0;
      last_sr     <= '0;
      cin_last_sr <= '0;
    end else if (clken) begin
      valid_sr[0]    <= s_valid;
      last_sr[0]     <= s_last;
      cin_last_sr[0] <= s_cin_last;
      for (int i = 1; i < LATENCY; i++) begin
        valid_sr[i]    <= valid_sr[i-1];
        last_sr[i]     <= last_sr[i-1];
        cin_last_sr[i] <= cin_last_sr[i-1];
      end
    end
  end

  assign mul_valid    = valid_sr[LATENCY-1];
  assign mul_last     = mul_valid & last_sr[LATENCY-1];
  assign mul_cin_last = mul_valid & cin_last_sr[LATENCY-1];

  // set out of reset and by each closing beat, cleared by the beat after it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_flag <= 1'b1;
    end else if (clken && mul_valid) begin
      load_flag <= mul_cin_last;
    end
  end

  assign acc_op = load_flag ? conv_pkg::ACC_LOAD : conv_pkg::ACC_ADD;
  assign acc_en = clken; // all accumulators step together here

  // the closing beat enters the sums on this same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid_q <= 1'b0;
      m_last_q  <= 1'b0;
    end else if (clken) begin
      m_valid_q <= mul_cin_last;
      m_last_q  <= mul_cin_last & mul_last;
    end
  end

  assign m_valid = m_valid_q & clken; // one enabled cycle per group
  assign m_last  = m_last_q & clken;

  // a group leaving on m_valid must leave the next beat to start a fresh sum
  a_output_reopens_group : assert property (
    @(posedge clk) disable iff (!arst_n)
    m_valid |-> acc_op == conv_pkg::ACC_LOAD
  ) else $error("conv_ctrl: output beat without a pending load");

  a_last_needs_valid : assert property (
    @(posedge clk) disable iff (!arst_n)
    m_last |-> m_valid
  ) else $error("conv_ctrl: m_last high without m_valid");

endmodule

//--- design/conv_engine.sv
// 1x1 convolution top, one copy and one group; m_data is only meaningful while m_valid is high
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_engine (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            clken,
  input  logic            s_valid,
  input  logic            s_last,
  input  logic            s_cin_last,
  input  conv_pkg::word_t s_pixels  [`CONV_UNITS],
  input  conv_pkg::word_t s_weights [`CONV_MEMBERS],
  output logic            m_valid,
  output logic            m_last,
  output conv_pkg::acc_t  m_data    [`CONV_MEMBERS][`CONV_UNITS]
);

  logic              mul_valid; // beat leaving the multipliers is real
  logic              acc_en;
  conv_pkg::acc_op_e acc_op;

  conv_pkg::prod_t mul_product [`CONV_MEMBERS][`CONV_UNITS];
  conv_pkg::prod_t acc_addend  [`CONV_MEMBERS][`CONV_UNITS];

  conv_ctrl ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_cin_last (s_cin_last),
    .mul_valid  (mul_valid),
    .acc_op     (acc_op),
    .acc_en     (acc_en),
    .m_valid    (m_valid),
    .m_last     (m_last)
  );

  // every member sees every pixel, each unit sees its member's weight
  for (genvar m = 0; m < `CONV_MEMBERS; m++) begin : gen_member
    for (genvar u = 0; u < `CONV_UNITS; u++) begin : gen_unit

      mul_pipe mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .en      (clken),
        .pixel   (s_pixels[u]),
        .weight  (s_weights[m]),
        .product (mul_product[m][u])
      );

      // idle slots add zero so sums hold across gaps in the input
      assign acc_addend[m][u] = mul_valid ? mul_product[m][u] : '0;

      acc_unit acc (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (acc_en),
        .op     (acc_op),
        .addend (acc_addend[m][u]),
        .sum    (m_data[m][u])
      );

    end
  end

endmodule

//--- testbench/conv_engine_tb.sv
// reads at most 64 beats from testbench/conv_patterns.txt, so it must run from the project root
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_engine_tb #(
  parameter int RAND_SEED = 32'h8241
);

  localparam int CLK_PERIOD = 20;
  localparam int UNITS      = `CONV_UNITS;
  localparam int MEMBERS    = `CONV_MEMBERS;
  localparam int LATENCY    = `CONV_LATENCY_MUL;
  localparam int BEAT_COLS  = 3 + UNITS + MEMBERS; // valid, last, cin_last, pixels, weights
  localparam int MAX_BEATS  = 64;

  logic            clk;
  logic            arst_n;
  logic            clken;
  logic            s_valid;
  logic            s_last;
  logic            s_cin_last;
  conv_pkg::word_t s_pixels  [UNITS];
  conv_pkg::word_t s_weights [MEMBERS];
  logic            m_valid;
  logic            m_last;
  conv_pkg::acc_t  m_data    [MEMBERS][UNITS];

  logic [7:0]      pat_mem [MAX_BEATS*BEAT_COLS];
  int              num_beats;
  int              watch_cycles = 0;
  integer          seed;

  conv_pkg::acc_t  run_sum [MEMBERS][UNITS]; // reference sums per member and unit
  logic            open_group;               // next valid beat starts a new sum
  conv_pkg::acc_t  exp_data_q [$];           // member major, unit minor
  logic            exp_last_q [$];

  conv_engine UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_cin_last (s_cin_last),
    .s_pixels   (s_pixels),
    .s_weights  (s_weights),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_data     (m_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  // about one cycle in four is stalled
  function automatic logic draw_clken();
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic load_patterns();
    $readmemh("testbench/conv_patterns.txt", pat_mem);
    num_beats = 0;
    while (num_beats < MAX_BEATS && pat_mem[num_beats*BEAT_COLS] != 8'hff) begin
      num_beats++;
    end
    if (num_beats == MAX_BEATS) begin
      stop_with_failure("the pattern file has no end marker line");
    end
  endtask

  // load on the first valid beat of a group, add on the others
  task automatic model_beat();
    conv_pkg::acc_t product;
    if (s_valid) begin
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          product = conv_pkg::acc_t'(s_pixels[u]) * conv_pkg::acc_t'(s_weights[m]);
          if (open_group) begin
            run_sum[m][u] = product;
          end else begin
            run_sum[m][u] += product;
          end
        end
      end
      open_group = s_cin_last;
      if (s_cin_last) begin
        for (int m = 0; m < MEMBERS; m++) begin
          for (int u = 0; u < UNITS; u++) begin
            exp_data_q.push_back(run_sum[m][u]);
          end
        end
        exp_last_q.push_back(s_last);
      end
    end
  endtask

  // the beat is offered again until an enabled cycle takes it
  task automatic drive_beat(input int b);
    int   base;
    logic taken;
    base  = b * BEAT_COLS;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      clken      = draw_clken();
      s_valid    = pat_mem[base][0];
      s_last     = pat_mem[base+1][0];
      s_cin_last = pat_mem[base+2][0];
      for (int u = 0; u < UNITS; u++) begin
        s_pixels[u] = pat_mem[base+3+u];
      end
      for (int m = 0; m < MEMBERS; m++) begin
        s_weights[m] = pat_mem[base+3+UNITS+m];
      end
      if (clken) begin
        model_beat();
        taken = 1'b1;
      end
    end
  endtask

  // sampled a quarter period before the rising edge that consumes the beat
  task automatic check_outputs();
    logic           exp_last;
    conv_pkg::acc_t exp_word;
    assert (!(m_valid && !clken)) else stop_with_failure("m_valid was high while clken was low");
    assert (!(m_last && !m_valid)) else stop_with_failure("m_last was high without m_valid");
    if (m_valid) begin
      assert (exp_last_q.size() != 0)
        else stop_with_failure("an output beat arrived while no group was pending");
      exp_last = exp_last_q.pop_front();
      assert (m_last == exp_last)
        else stop_with_failure($sformatf("error m_last got 0x%0h expected 0x%0h",
                                         m_last, exp_last));
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          exp_word = exp_data_q.pop_front();
          assert (m_data[m][u] == exp_word)
            else stop_with_failure($sformatf("error m_data[%0d][%0d] got 0x%06h expected 0x%06h",
                                             m, u, m_data[m][u], exp_word));
        end
      end
    end
  endtask

  initial begin : monitor
    forever begin
      @(negedge clk);
      #(CLK_PERIOD/4);
      check_outputs();
    end
  end

  initial begin : watchdog
    wait (watch_cycles != 0);
    #(watch_cycles * CLK_PERIOD);
    stop_with_failure("timeout, the output beats did not arrive in time");
  end

  initial begin : stimulus
    int idle_enabled;
    clk        = 1'b0;
    arst_n     = 1'b0;
    clken      = 1'b0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    s_cin_last = 1'b0;
    for (int u = 0; u < UNITS; u++) begin
      s_pixels[u] = '0;
    end
    for (int m = 0; m < MEMBERS; m++) begin
      s_weights[m] = '0;
    end
    seed       = RAND_SEED;
    open_group = 1'b1;
    load_patterns();
    watch_cycles = (num_beats + LATENCY + 10) * 4; // margin for stalled cycles
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (int b = 0; b < num_beats; b++) begin
      drive_beat(b);
    end
    idle_enabled = 0;
    while (idle_enabled < LATENCY + 3) begin // flush the pipeline
      @(negedge clk);
      clken      = draw_clken();
      s_valid    = 1'b0;
      s_last     = 1'b0;
      s_cin_last = 1'b0;
      if (clken) begin
        idle_enabled++;
      end
    end
    repeat (2) @(negedge clk);
    if (exp_last_q.size() != 0) begin
      stop_with_failure($sformatf("%0d expected output beats never arrived", exp_last_q.size()));
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- build.f
+incdir+design
design/conv_pkg.sv
design/mul_pipe.sv
design/acc_unit.sv
design/conv_ctrl.sv
design/conv_engine.sv
testbench/conv_engine_tb.sv

//--- Makefile
# Verilator build and run of the 1x1 convolution engine testbench

VERILATOR ?= verilator
TOP       ?= conv_engine_tb
# 33345 is 0x8241, the testbench default
SEED      ?= 33345
VFLAGS    ?=
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED)"
	@echo "           VFLAGS=$(VFLAGS) OBJDIR=$(OBJDIR)"

# the run must start in the project root, the pattern path is relative to it
test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f build.f \
		--top-module $(TOP) -GRAND_SEED=$(SEED) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- testbench/conv_patterns.txt
// columns: valid last cin_last pixel0 pixel1 weight0 weight1 weight2 weight3, hex bytes
// words are two's complement; a line whose valid column is ff ends the list
// single-beat groups with extreme and negative operands
01 00 01 7f 80 01 ff 80 7f
01 00 01 fd 05 03 fe 7f 80
01 00 01 80 80 80 7f 00 ff
// three-beat group
01 00 00 10 f0 02 03 fc 05
01 00 00 20 e0 ff 01 02 81
01 00 01 05 fb 7f 80 10 f0
// idle beats inside a group, their flags and data must be ignored
01 00 00 11 22 01 02 03 04
00 01 01 7f 7f 7f 7f 7f 7f
01 00 00 33 44 05 06 07 08
00 00 00 55 55 55 55 55 55
00 00 01 80 80 80 80 80 80
01 01 01 99 aa f1 f2 f3 f4
// back-to-back single-beat groups, some closing with last
01 01 01 02 03 04 05 06 07
01 00 01 fe fd fc fb fa f9
01 01 01 40 c0 40 c0 40 c0
01 00 01 01 ff 7f 80 01 ff
// idle gap between groups
00 00 00 00 00 00 00 00 00
00 01 00 12 34 56 78 9a bc
// long run, last on an inner beat does not mark the output
01 00 00 7f 7f 7f 7f 7f 7f
01 01 00 80 80 80 80 80 80
01 00 00 7f 80 80 7f 7f 80
01 00 00 81 81 81 81 81 81
01 00 00 c3 3c 5a a5 0f f0
01 00 00 64 9c 32 ce 19 e7
01 00 00 01 02 03 04 05 06
01 00 01 ff fe fd fc fb fa
// two-beat groups back to back
01 00 00 0a f6 14 ec 1e e2
01 00 01 28 d8 32 ce 3c c4
01 00 00 03 07 0b 0d 11 13
01 01 01 fb f9 f5 f3 ef ed
// idle before and inside a group
00 00 00 ff ff ff ff ff ff
01 00 00 06 fa 0c f4 12 ee
00 00 00 ee ee ee ee ee ee
01 00 00 18 e8 1e e2 24 dc
01 01 01 2a d6 30 d0 36 ca
// closing group without last
01 00 01 55 ab 66 9a 77 89
// end marker
ff 00 00 00 00 00 00 00 00
